/* src/rv_fetch_pkg.sv */
package rv_fetch_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] addr_t;
    typedef logic [xlen-1:0] word_t;
    typedef logic [3:0]      cfg_addr_t;
    typedef logic [1:0]      axi_resp_t;

    // Configuration register map.
    localparam cfg_addr_t cfg_ctrl_off = 4'h0;  // Bit 0 is fetch enable.
    localparam cfg_addr_t cfg_boot_off = 4'h4;

    localparam addr_t boot_reset_value = 32'h8000_0000;

    localparam axi_resp_t resp_okay   = 2'b00;
    localparam axi_resp_t resp_slverr = 2'b10;

    typedef enum logic [1:0] {
        f_idle,
        f_addr,
        f_data,
        f_out
    } fetch_state_t;

endpackage

/* src/fetch_cfg.sv */
`timescale 1ns/10ps

module fetch_cfg #(
    parameter rv_fetch_pkg::addr_t boot_reset = rv_fetch_pkg::boot_reset_value
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cfg_awvalid,
    output logic                    cfg_awready,
    input  rv_fetch_pkg::cfg_addr_t cfg_awaddr,
    input  logic                    cfg_wvalid,
    output logic                    cfg_wready,
    input  rv_fetch_pkg::word_t     cfg_wdata,
    output logic                    cfg_bvalid,
    input  logic                    cfg_bready,
    output rv_fetch_pkg::axi_resp_t cfg_bresp,
    input  logic                    cfg_arvalid,
    output logic                    cfg_arready,
    input  rv_fetch_pkg::cfg_addr_t cfg_araddr,
    output logic                    cfg_rvalid,
    input  logic                    cfg_rready,
    output rv_fetch_pkg::word_t     cfg_rdata,
    output rv_fetch_pkg::axi_resp_t cfg_rresp,
    output logic                    fetch_en,
    output rv_fetch_pkg::addr_t     boot_pc
);
    import rv_fetch_pkg::*;

    logic      aw_full;
    logic      w_full;
    cfg_addr_t aw_addr_q;
    word_t     w_data_q;
    logic      aw_hs;
    logic      w_hs;
    logic      ar_hs;
    logic      wr_go;
    cfg_addr_t wr_addr;
    word_t     wr_data;

    assign cfg_awready = !aw_full && !cfg_bvalid;  // Stalls while b is pending.
    assign cfg_wready  = !w_full && !cfg_bvalid;
    assign cfg_arready = !cfg_rvalid;

    assign aw_hs = cfg_awvalid && cfg_awready;
    assign w_hs  = cfg_wvalid && cfg_wready;
    assign ar_hs = cfg_arvalid && cfg_arready;

    // Address and data may arrive in either order or together.
    assign wr_go   = (aw_full || aw_hs) && (w_full || w_hs);
    assign wr_addr = aw_full ? aw_addr_q : cfg_awaddr;
    assign wr_data = w_full ? w_data_q : cfg_wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_full    <= 1'b0;
            w_full     <= 1'b0;
            cfg_bvalid <= 1'b0;
            cfg_bresp  <= resp_okay;
            cfg_rvalid <= 1'b0;
            cfg_rresp  <= resp_okay;
            fetch_en   <= 1'b0;
            boot_pc    <= boot_reset;
        end else begin
            if (wr_go) begin
                aw_full    <= 1'b0;
                w_full     <= 1'b0;
                cfg_bvalid <= 1'b1;
                cfg_bresp  <= resp_okay;
                case (wr_addr)
                    cfg_ctrl_off: fetch_en <= wr_data[0];
                    cfg_boot_off: boot_pc <= wr_data;
                    default:      cfg_bresp <= resp_slverr;
                endcase
            end else begin
                if (aw_hs) aw_full <= 1'b1;
                if (w_hs) w_full <= 1'b1;
                if (cfg_bvalid && cfg_bready) cfg_bvalid <= 1'b0;
            end

            if (ar_hs) begin
                cfg_rvalid <= 1'b1;
                cfg_rresp  <= (cfg_araddr == cfg_ctrl_off || cfg_araddr == cfg_boot_off) ?
                              resp_okay : resp_slverr;
            end else if (cfg_rready) begin
                cfg_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) aw_addr_q <= cfg_awaddr;
        if (w_hs) w_data_q <= cfg_wdata;
        if (ar_hs) begin
            case (cfg_araddr)
                cfg_ctrl_off: cfg_rdata <= {{(xlen-1){1'b0}}, fetch_en};
                cfg_boot_off: cfg_rdata <= boot_pc;
                default:      cfg_rdata <= '0;  // Unmapped reads as zero.
            endcase
        end
    end

endmodule

/* src/pc_gen.sv */
`timescale 1ns/10ps

module pc_gen (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fetch_en,
    input  rv_fetch_pkg::addr_t boot_pc,
    input  logic                redirect,
    input  rv_fetch_pkg::addr_t redirect_pc,
    input  logic                advance,
    output rv_fetch_pkg::addr_t pc,
    output logic                flush
);
    import rv_fetch_pkg::*;

    addr_t pc_next;

    // Redirect takes priority over a delivery in the same cycle.
    always_comb begin
        pc_next = pc;
        if (!fetch_en) begin
            pc_next = boot_pc;  // Parked on boot while disabled.
        end else if (redirect) begin
            pc_next = redirect_pc;
        end else if (advance) begin
            pc_next = pc + addr_t'(4);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // Tells the fetch engine its request is on the old path.
    assign flush = fetch_en && redirect;

endmodule

/* src/fetch_axi_rd.sv */
`timescale 1ns/10ps

module fetch_axi_rd (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    fetch_en,
    input  logic                    hold,
    input  rv_fetch_pkg::addr_t     pc,
    input  logic                    flush,
    output logic                    advance,
    output logic                    imem_arvalid,
    input  logic                    imem_arready,
    output rv_fetch_pkg::addr_t     imem_araddr,
    input  logic                    imem_rvalid,
    output logic                    imem_rready,
    input  rv_fetch_pkg::word_t     imem_rdata,
    input  rv_fetch_pkg::axi_resp_t imem_rresp,
    output logic                    inst_valid,
    output rv_fetch_pkg::addr_t     inst_pc,
    output rv_fetch_pkg::word_t     inst_data,
    input  logic                    inst_ready
);
    import rv_fetch_pkg::*;

    fetch_state_t state;
    fetch_state_t state_next;
    logic         stale;
    logic         kill;
    addr_t        req_pc;

    // Disabling fetch discards in-flight work just like a redirect.
    assign kill = flush || !fetch_en;

    always_comb begin
        state_next = state;
        case (state)
            f_idle: begin
                if (fetch_en && !hold && !flush) state_next = f_addr;
            end
            f_addr: begin
                if (imem_arready) state_next = f_data;
            end
            f_data: begin
                if (imem_rvalid) state_next = (stale || kill) ? f_idle : f_out;
            end
            f_out: begin
                if (inst_ready || kill) state_next = f_idle;
            end
            default: state_next = f_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= f_idle;
            stale <= 1'b0;
        end else begin
            state <= state_next;
            if (state == f_data && imem_rvalid) begin
                stale <= 1'b0;
            end else if (kill && (state == f_addr || state == f_data)) begin
                stale <= 1'b1;  // Response still has to be drained.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == f_idle && state_next == f_addr) req_pc <= pc;
        if (state == f_data && imem_rvalid) inst_data <= imem_rdata;
    end

    // Only one read is ever outstanding.
    assign imem_arvalid = (state == f_addr);
    assign imem_rready  = (state == f_data);
    assign imem_araddr  = req_pc;

    assign inst_valid = (state == f_out);
    assign inst_pc    = req_pc;
    assign advance    = inst_valid && inst_ready;

endmodule

/* src/rv_fetch.sv */
`timescale 1ns/10ps

module rv_fetch #(
    parameter rv_fetch_pkg::addr_t boot_reset = rv_fetch_pkg::boot_reset_value
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cfg_awvalid,
    output logic                    cfg_awready,
    input  rv_fetch_pkg::cfg_addr_t cfg_awaddr,
    input  logic                    cfg_wvalid,
    output logic                    cfg_wready,
    input  rv_fetch_pkg::word_t     cfg_wdata,
    output logic                    cfg_bvalid,
    input  logic                    cfg_bready,
    output rv_fetch_pkg::axi_resp_t cfg_bresp,
    input  logic                    cfg_arvalid,
    output logic                    cfg_arready,
    input  rv_fetch_pkg::cfg_addr_t cfg_araddr,
    output logic                    cfg_rvalid,
    input  logic                    cfg_rready,
    output rv_fetch_pkg::word_t     cfg_rdata,
    output rv_fetch_pkg::axi_resp_t cfg_rresp,
    output logic                    imem_arvalid,
    input  logic                    imem_arready,
    output rv_fetch_pkg::addr_t     imem_araddr,
    input  logic                    imem_rvalid,
    output logic                    imem_rready,
    input  rv_fetch_pkg::word_t     imem_rdata,
    input  rv_fetch_pkg::axi_resp_t imem_rresp,
    output logic                    inst_valid,
    output rv_fetch_pkg::addr_t     inst_pc,
    output rv_fetch_pkg::word_t     inst_data,
    input  logic                    inst_ready,
    input  logic                    redirect,
    input  rv_fetch_pkg::addr_t     redirect_pc,
    input  logic                    hold
);
    import rv_fetch_pkg::*;

    logic  fetch_en;
    addr_t boot_pc;
    addr_t pc;
    logic  flush;
    logic  advance;

    fetch_cfg #(
        .boot_reset(boot_reset)
    ) i_cfg (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_awvalid(cfg_awvalid),
        .cfg_awready(cfg_awready),
        .cfg_awaddr (cfg_awaddr),
        .cfg_wvalid (cfg_wvalid),
        .cfg_wready (cfg_wready),
        .cfg_wdata  (cfg_wdata),
        .cfg_bvalid (cfg_bvalid),
        .cfg_bready (cfg_bready),
        .cfg_bresp  (cfg_bresp),
        .cfg_arvalid(cfg_arvalid),
        .cfg_arready(cfg_arready),
        .cfg_araddr (cfg_araddr),
        .cfg_rvalid (cfg_rvalid),
        .cfg_rready (cfg_rready),
        .cfg_rdata  (cfg_rdata),
        .cfg_rresp  (cfg_rresp),
        .fetch_en   (fetch_en),
        .boot_pc    (boot_pc)
    );

    pc_gen i_pc (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_en   (fetch_en),
        .boot_pc    (boot_pc),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .advance    (advance),
        .pc         (pc),
        .flush      (flush)
    );

    fetch_axi_rd i_rd (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_en    (fetch_en),
        .hold        (hold),
        .pc          (pc),
        .flush       (flush),
        .advance     (advance),
        .imem_arvalid(imem_arvalid),
        .imem_arready(imem_arready),
        .imem_araddr (imem_araddr),
        .imem_rvalid (imem_rvalid),
        .imem_rready (imem_rready),
        .imem_rdata  (imem_rdata),
        .imem_rresp  (imem_rresp),
        .inst_valid  (inst_valid),
        .inst_pc     (inst_pc),
        .inst_data   (inst_data),
        .inst_ready  (inst_ready)
    );

endmodule

/* testbench/rv_fetch_chk.sv */
`timescale 1ns/10ps

module rv_fetch_chk (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    fetch_en,
    input logic                    flush,
    input logic                    imem_arvalid,
    input logic                    imem_arready,
    input rv_fetch_pkg::addr_t     imem_araddr,
    input logic                    cfg_bvalid,
    input logic                    cfg_bready,
    input rv_fetch_pkg::axi_resp_t cfg_bresp,
    input logic                    inst_valid,
    input logic                    inst_ready,
    input rv_fetch_pkg::addr_t     inst_pc,
    input rv_fetch_pkg::word_t     inst_data
);

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        imem_arvalid && !imem_arready |=> imem_arvalid && $stable(imem_araddr))
        else $error("imem_arvalid dropped or imem_araddr changed before the handshake");

    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_bvalid && !cfg_bready |=> cfg_bvalid && $stable(cfg_bresp))
        else $error("cfg_bvalid dropped or cfg_bresp changed before the handshake");

    // A flush or a disable may drop a word that decode has not taken.
    a_inst_hold: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid && !inst_ready && fetch_en && !flush
        |=> inst_valid && $stable(inst_pc) && $stable(inst_data))
        else $error("inst_valid dropped or its payload changed before the handshake");

    a_reset: assert property (@(posedge clk) !rst_n |-> !inst_valid)
        else $error("inst_valid high during reset");

endmodule

bind rv_fetch rv_fetch_chk i_chk (.*);

/* testbench/tb_rv_fetch.sv */
`timescale 1ns/10ps

module tb_rv_fetch;
    import rv_fetch_pkg::*;

    typedef struct packed {
        addr_t boot;
        int    count;
        int    redir_after;  // Zero means no redirect.
        addr_t redir_pc;
        int    hold_cycles;  // Hold goes high after the first delivery.
    } row_t;

    localparam int num_rows = 5;

    row_t rows [num_rows] = '{
        '{32'h0000_1000, 10, 0, 32'h0000_0000, 0},
        '{32'h0000_2000, 12, 4, 32'h0000_3000, 0},
        '{32'h0000_4000, 8,  0, 32'h0000_0000, 6},
        '{32'h8000_0100, 10, 3, 32'h8000_0800, 5},
        '{32'hffff_fff0, 8,  0, 32'h0000_0000, 0}   // Wraps past zero.
    };

    logic      clk = 1'b0;
    logic      rst_n;
    logic      cfg_awvalid, cfg_awready;
    cfg_addr_t cfg_awaddr;
    logic      cfg_wvalid, cfg_wready;
    word_t     cfg_wdata;
    logic      cfg_bvalid, cfg_bready;
    axi_resp_t cfg_bresp;
    logic      cfg_arvalid, cfg_arready;
    cfg_addr_t cfg_araddr;
    logic      cfg_rvalid, cfg_rready;
    word_t     cfg_rdata;
    axi_resp_t cfg_rresp;
    logic      imem_arvalid, imem_arready;
    addr_t     imem_araddr;
    logic      imem_rvalid, imem_rready;
    word_t     imem_rdata;
    axi_resp_t imem_rresp;
    logic      inst_valid, inst_ready;
    addr_t     inst_pc;
    word_t     inst_data;
    logic      redirect;
    addr_t     redirect_pc;
    logic      hold;

    int cycles = 0;
    int cycle_limit;

    rv_fetch i_dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Errors found");
            $fatal(1, "cycle limit reached");
        end
    end

    // Inputs change just after the rising edge.
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_pc(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("Errors found");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("Errors found");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
        if (act !== exp) begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("Errors found");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic cfg_write(input cfg_addr_t addr, input word_t data);
        logic aw_done;
        logic w_done;
        aw_done     = 1'b0;
        w_done      = 1'b0;
        cfg_awvalid = 1'b1;
        cfg_awaddr  = addr;
        cfg_wvalid  = 1'b1;
        cfg_wdata   = data;
        cfg_bready  = 1'b1;
        while (!(aw_done && w_done)) begin
            if (cfg_awvalid && cfg_awready) aw_done = 1'b1;
            if (cfg_wvalid && cfg_wready) w_done = 1'b1;
            next_cycle();
            if (aw_done) cfg_awvalid = 1'b0;
            if (w_done) cfg_wvalid = 1'b0;
        end
        while (!cfg_bvalid) next_cycle();
        check_resp("cfg_bresp", resp_okay, cfg_bresp);
        next_cycle();
        cfg_bready = 1'b0;
    endtask

    task automatic cfg_read(input cfg_addr_t addr, output word_t data, output axi_resp_t resp);
        cfg_arvalid = 1'b1;
        cfg_araddr  = addr;
        cfg_rready  = 1'b1;
        while (!cfg_arready) next_cycle();
        next_cycle();
        cfg_arvalid = 1'b0;
        while (!cfg_rvalid) next_cycle();
        data = cfg_rdata;
        resp = cfg_rresp;
        next_cycle();
        cfg_rready = 1'b0;
    endtask

    // Memory answers each read with the inverted address.
    initial begin
        addr_t addr;
        imem_arready = 1'b0;
        imem_rvalid  = 1'b0;
        imem_rdata   = '0;
        imem_rresp   = resp_okay;
        forever begin
            if (imem_arvalid === 1'b1) begin
                repeat ($urandom_range(3)) next_cycle();
                imem_arready = 1'b1;
                addr = imem_araddr;
                next_cycle();
                imem_arready = 1'b0;
                repeat ($urandom_range(3)) next_cycle();
                imem_rvalid = 1'b1;
                imem_rdata  = ~addr;
                while (imem_rready !== 1'b1) next_cycle();
                next_cycle();
                imem_rvalid = 1'b0;
            end else begin
                next_cycle();
            end
        end
    end

    initial begin
        word_t     rd_data;
        axi_resp_t rd_resp;
        addr_t     exp_pc;
        int        n;
        int        hold_left;
        logic      delivered;

        void'($urandom(91572));
        cycle_limit = 200;
        foreach (rows[r]) cycle_limit += 20 * rows[r].count;
        rst_n       = 1'b0;
        cfg_awvalid = 1'b0;
        cfg_awaddr  = '0;
        cfg_wvalid  = 1'b0;
        cfg_wdata   = '0;
        cfg_bready  = 1'b0;
        cfg_arvalid = 1'b0;
        cfg_araddr  = '0;
        cfg_rready  = 1'b0;
        inst_ready  = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        hold        = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();

        cfg_read(cfg_ctrl_off, rd_data, rd_resp);
        check_word("cfg_rdata", 32'h0000_0000, rd_data);
        check_resp("cfg_rresp", resp_okay, rd_resp);
        cfg_read(cfg_boot_off, rd_data, rd_resp);
        check_word("cfg_rdata", 32'h8000_0000, rd_data);
        check_resp("cfg_rresp", resp_okay, rd_resp);
        cfg_read(4'h8, rd_data, rd_resp);
        check_word("cfg_rdata", 32'h0000_0000, rd_data);
        check_resp("cfg_rresp", resp_slverr, rd_resp);

        foreach (rows[r]) begin
            cfg_write(cfg_ctrl_off, 32'h0000_0000);
            cfg_write(cfg_boot_off, rows[r].boot);
            cfg_read(cfg_boot_off, rd_data, rd_resp);
            check_word("cfg_rdata", rows[r].boot, rd_data);
            cfg_write(cfg_ctrl_off, 32'h0000_0001);
            exp_pc    = rows[r].boot;
            n         = 0;
            hold_left = 0;
            while (n < rows[r].count) begin
                hold = (hold_left > 0);
                if (hold_left > 0) hold_left--;
                inst_ready = ($urandom_range(3) != 0);
                delivered  = inst_valid && inst_ready;
                if (delivered) begin
                    check_pc("inst_pc", exp_pc, inst_pc);
                    check_word("inst_data", ~exp_pc, inst_data);
                    // Hold rises while the engine is idle, so nothing is in flight.
                    if (hold) begin
                        $display("An instruction was delivered while hold was high");
                        $display("Errors found");
                        $fatal(1, "hold not respected");
                    end
                end
                next_cycle();
                if (delivered) begin
                    n++;
                    exp_pc = exp_pc + 32'd4;
                    if (n == 1) hold_left = rows[r].hold_cycles;
                    if (n == rows[r].redir_after) begin
                        // Let a read get in flight so the flush has work to do.
                        inst_ready = 1'b0;
                        repeat ($urandom_range(3)) next_cycle();
                        redirect    = 1'b1;
                        redirect_pc = rows[r].redir_pc;
                        next_cycle();
                        redirect = 1'b0;
                        exp_pc   = rows[r].redir_pc;
                    end
                end
            end
            hold       = 1'b0;
            inst_ready = 1'b0;
        end

        $display("No errors");
        $finish;
    end

endmodule

/* rv_fetch.f */
src/rv_fetch_pkg.sv
src/fetch_cfg.sv
src/pc_gen.sv
src/fetch_axi_rd.sv
src/rv_fetch.sv
testbench/rv_fetch_chk.sv
testbench/tb_rv_fetch.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the fetch front end testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_rv_fetch \
        -f rv_fetch.f --Mdir obj_dir -o sim_tb_rv_fetch; then
    echo "Build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_rv_fetch 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" <<< "$output"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
